// File: src/stream_pkg.sv
package stream_pkg;

    // one stream data byte
    typedef logic [7:0] byte_t;

    // packet opcode from the header
    typedef logic [1:0] op_t;

    // operand from the header
    typedef logic [5:0] key_t;

    // opcode values
    localparam op_t OP_PASS = 2'd0;
    localparam op_t OP_XOR  = 2'd1;
    localparam op_t OP_ADD  = 2'd2;

    // drop in the header, and the payload-free last marker past decode
    localparam op_t OP_DROP = 2'd3;

    // header layout, opcode on top and key below it
    localparam int HDR_OP_MSB  = 7;
    localparam int HDR_OP_LSB  = 6;
    localparam int HDR_KEY_MSB = 5;

endpackage

// File: src/byte_stream_if.sv
`timescale 1ns/1ns

// byte stream with opcode and key carried alongside each beat
interface byte_stream_if;

    stream_pkg::byte_t data;
    logic              valid;
    logic              ready;
    logic              last;
    stream_pkg::op_t   op;
    stream_pkg::key_t  key;

    modport source (
        output data,
        output valid,
        output last,
        output op,
        output key,
        input  ready
    );

    modport sink (
        input  data,
        input  valid,
        input  last,
        input  op,
        input  key,
        output ready
    );

endinterface

// File: src/axis_register.sv
`timescale 1ns/1ns

module axis_register #(
    // 0 bypass, 1 simple buffer, 2 skid buffer
    parameter int REG_TYPE = 2
) (
    input  logic              clk,
    input  logic              rst,
    input  stream_pkg::byte_t s_data,
    input  logic              s_valid,
    input  logic              s_last,
    output logic              s_ready,
    output stream_pkg::byte_t m_data,
    output logic              m_valid,
    output logic              m_last,
    input  logic              m_ready
);

    if (REG_TYPE > 1) begin : g_skid
        logic              ready_reg;
        logic              out_valid;
        logic              out_valid_next;
        stream_pkg::byte_t out_data;
        logic              out_last;
        logic              tmp_valid;
        logic              tmp_valid_next;
        stream_pkg::byte_t tmp_data;
        logic              tmp_last;
        logic              store_in_out;
        logic              store_in_tmp;
        logic              store_tmp_out;
        logic              ready_early;

        assign s_ready = ready_reg;
        assign m_data  = out_data;
        assign m_valid = out_valid;
        assign m_last  = out_last;

        // ready next cycle unless the temp register could fill up
        assign ready_early = m_ready || (!tmp_valid && (!out_valid || !s_valid));

        always_comb begin
            out_valid_next = out_valid;
            tmp_valid_next = tmp_valid;
            store_in_out   = 1'b0;
            store_in_tmp   = 1'b0;
            store_tmp_out  = 1'b0;
            if (ready_reg) begin
                if (m_ready || !out_valid) begin
                    out_valid_next = s_valid;
                    store_in_out   = 1'b1;
                end else begin
                    // output stalled, park the beat
                    tmp_valid_next = s_valid;
                    store_in_tmp   = 1'b1;
                end
            end else if (m_ready) begin
                out_valid_next = tmp_valid;
                tmp_valid_next = 1'b0;
                store_tmp_out  = 1'b1;
            end
        end

        always_ff @(posedge clk) begin
            if (rst) begin
                ready_reg <= 1'b0;
                out_valid <= 1'b0;
                tmp_valid <= 1'b0;
            end else begin
                ready_reg <= ready_early;
                out_valid <= out_valid_next;
                tmp_valid <= tmp_valid_next;
            end
            if (store_in_out) begin
                out_data <= s_data;
                out_last <= s_last;
            end else if (store_tmp_out) begin
                out_data <= tmp_data;
                out_last <= tmp_last;
            end
            if (store_in_tmp) begin
                tmp_data <= s_data;
                tmp_last <= s_last;
            end
        end
    end else if (REG_TYPE == 1) begin : g_simple
        logic              ready_reg;
        logic              out_valid;
        logic              out_valid_next;
        stream_pkg::byte_t out_data;
        logic              out_last;

        assign s_ready = ready_reg;
        assign m_data  = out_data;
        assign m_valid = out_valid;
        assign m_last  = out_last;

        // ready only while empty, hence the bubble
        always_comb begin
            out_valid_next = out_valid;
            if (ready_reg) begin
                out_valid_next = s_valid;
            end else if (m_ready) begin
                out_valid_next = 1'b0;
            end
        end

        always_ff @(posedge clk) begin
            if (rst) begin
                ready_reg <= 1'b0;
                out_valid <= 1'b0;
            end else begin
                ready_reg <= !out_valid_next;
                out_valid <= out_valid_next;
            end
            if (ready_reg) begin
                out_data <= s_data;
                out_last <= s_last;
            end
        end
    end else begin : g_bypass
        assign m_data  = s_data;
        assign m_valid = s_valid;
        assign m_last  = s_last;
        assign s_ready = m_ready;
    end

endmodule

// File: src/packet_decode.sv
`timescale 1ns/1ns

module packet_decode (
    input logic           clk,
    input logic           rst,
    byte_stream_if.sink   s,
    byte_stream_if.source m
);

    typedef enum logic [1:0] {
        HEADER,
        PAYLOAD,
        DISCARD
    } state_t;

    state_t            state;
    state_t            state_next;
    stream_pkg::op_t   hdr_op;
    stream_pkg::key_t  hdr_key;
    stream_pkg::op_t   op_reg;
    stream_pkg::key_t  key_reg;
    logic              out_valid;
    stream_pkg::byte_t out_data;
    logic              out_last;
    stream_pkg::op_t   out_op;
    stream_pkg::key_t  out_key;
    logic              out_free;
    logic              in_xfer;
    logic              latch_hdr;
    logic              load_payload;
    logic              load_marker;

    assign hdr_op  = s.data[stream_pkg::HDR_OP_MSB:stream_pkg::HDR_OP_LSB];
    assign hdr_key = s.data[stream_pkg::HDR_KEY_MSB:0];

    // output register takes a beat while empty or draining
    assign out_free = !out_valid || m.ready;
    assign s.ready  = (state == DISCARD) || out_free;
    assign in_xfer  = s.valid && s.ready;

    assign m.valid = out_valid;
    assign m.data  = out_data;
    assign m.last  = out_last;
    assign m.op    = out_op;
    assign m.key   = out_key;

    always_comb begin
        state_next   = state;
        latch_hdr    = 1'b0;
        load_payload = 1'b0;
        load_marker  = 1'b0;
        if (in_xfer) begin
            case (state)
                HEADER: begin
                    if (hdr_op == stream_pkg::OP_DROP) begin
                        if (!s.last) begin
                            state_next = DISCARD;
                        end
                    end else if (s.last) begin
                        // header only, send just the end marker
                        load_marker = 1'b1;
                    end else begin
                        latch_hdr  = 1'b1;
                        state_next = PAYLOAD;
                    end
                end
                PAYLOAD: begin
                    load_payload = 1'b1;
                    if (s.last) begin
                        state_next = HEADER;
                    end
                end
                DISCARD: begin
                    if (s.last) begin
                        state_next = HEADER;
                    end
                end
                default: state_next = HEADER;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state     <= HEADER;
            out_valid <= 1'b0;
        end else begin
            state <= state_next;
            if (m.ready) begin
                out_valid <= 1'b0;
            end
            if (load_payload || load_marker) begin
                out_valid <= 1'b1;
            end
        end
        if (latch_hdr) begin
            op_reg  <= hdr_op;
            key_reg <= hdr_key;
        end
        if (load_payload) begin
            out_data <= s.data;
            out_last <= s.last;
            out_op   <= op_reg;
            out_key  <= key_reg;
        end else if (load_marker) begin
            out_data <= '0;
            out_last <= 1'b1;
            out_op   <= stream_pkg::OP_DROP;
            out_key  <= '0;
        end
    end

endmodule

// File: src/payload_execute.sv
`timescale 1ns/1ns

module payload_execute (
    input logic           clk,
    input logic           rst,
    byte_stream_if.sink   s,
    byte_stream_if.source m
);

    logic              out_valid;
    stream_pkg::byte_t out_data;
    logic              out_last;
    stream_pkg::op_t   out_op;
    stream_pkg::key_t  out_key;
    stream_pkg::byte_t key_ext;
    stream_pkg::byte_t result;
    logic              in_xfer;

    // one beat per register, refilled as it drains
    assign s.ready = !out_valid || m.ready;
    assign in_xfer = s.valid && s.ready;

    assign key_ext = {2'b00, s.key};

    always_comb begin
        case (s.op)
            stream_pkg::OP_XOR: result = s.data ^ key_ext;
            stream_pkg::OP_ADD: result = s.data + key_ext;
            // pass, and the marker which carries no byte
            default: result = s.data;
        endcase
    end

    assign m.valid = out_valid;
    assign m.data  = out_data;
    assign m.last  = out_last;
    assign m.op    = out_op;
    assign m.key   = out_key;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
        end else begin
            if (m.ready) begin
                out_valid <= 1'b0;
            end
            if (in_xfer) begin
                out_valid <= 1'b1;
            end
        end
        if (in_xfer) begin
            out_data <= result;
            out_last <= s.last;
            out_op   <= s.op;
            out_key  <= s.key;
        end
    end

endmodule

// File: src/checksum_append.sv
`timescale 1ns/1ns

module checksum_append (
    input  logic              clk,
    input  logic              rst,
    byte_stream_if.sink       s,
    output stream_pkg::byte_t m_data,
    output logic              m_valid,
    output logic              m_last,
    input  logic              m_ready
);

    logic              out_valid;
    stream_pkg::byte_t out_data;
    logic              out_last;
    stream_pkg::byte_t sum;
    logic              cs_pend;
    logic              out_free;
    logic              in_xfer;
    logic              is_marker;
    logic              send_sum;

    assign out_free  = !out_valid || m_ready;
    // input held off while the checksum beat goes out
    assign s.ready   = !cs_pend && out_free;
    assign in_xfer   = s.valid && s.ready;
    assign is_marker = (s.op == stream_pkg::OP_DROP);
    assign send_sum  = cs_pend && out_free;

    assign m_data  = out_data;
    assign m_valid = out_valid;
    assign m_last  = out_last;

    always_ff @(posedge clk) begin
        if (rst) begin
            out_valid <= 1'b0;
            sum       <= '0;
            cs_pend   <= 1'b0;
        end else begin
            if (m_ready) begin
                out_valid <= 1'b0;
            end
            if (send_sum) begin
                out_valid <= 1'b1;
                sum       <= '0;
                cs_pend   <= 1'b0;
            end else if (in_xfer) begin
                out_valid <= 1'b1;
                if (is_marker) begin
                    // no payload byte, checksum goes out directly
                    sum <= '0;
                end else begin
                    sum     <= sum + s.data;
                    cs_pend <= s.last;
                end
            end
        end
        if (send_sum) begin
            out_data <= sum;
            out_last <= 1'b1;
        end else if (in_xfer) begin
            if (is_marker) begin
                out_data <= sum;
                out_last <= 1'b1;
            end else begin
                out_data <= s.data;
                out_last <= 1'b0;
            end
        end
    end

endmodule

// File: src/stream_proc_top.sv
`timescale 1ns/1ns

module stream_proc_top #(
    parameter int IN_REG_TYPE  = 2,
    parameter int OUT_REG_TYPE = 2
) (
    input  logic              clk,
    input  logic              rst,
    input  stream_pkg::byte_t in_data,
    input  logic              in_valid,
    output logic              in_ready,
    input  logic              in_last,
    output stream_pkg::byte_t out_data,
    output logic              out_valid,
    input  logic              out_ready,
    output logic              out_last
);

    byte_stream_if dec_if ();
    byte_stream_if exe_if ();
    byte_stream_if res_if ();

    // checksum stage to output slice
    stream_pkg::byte_t chk_data;
    logic              chk_valid;
    logic              chk_last;
    logic              chk_ready;

    axis_register #(.REG_TYPE(IN_REG_TYPE)) in_slice (
        .clk     (clk),
        .rst     (rst),
        .s_data  (in_data),
        .s_valid (in_valid),
        .s_last  (in_last),
        .s_ready (in_ready),
        .m_data  (dec_if.data),
        .m_valid (dec_if.valid),
        .m_last  (dec_if.last),
        .m_ready (dec_if.ready)
    );

    // raw input has no sideband yet
    assign dec_if.op  = '0;
    assign dec_if.key = '0;

    packet_decode u_decode (.clk(clk), .rst(rst), .s(dec_if.sink), .m(exe_if.source));

    payload_execute u_execute (.clk(clk), .rst(rst), .s(exe_if.sink), .m(res_if.source));

    checksum_append u_result (
        .clk     (clk),
        .rst     (rst),
        .s       (res_if.sink),
        .m_data  (chk_data),
        .m_valid (chk_valid),
        .m_last  (chk_last),
        .m_ready (chk_ready)
    );

    axis_register #(.REG_TYPE(OUT_REG_TYPE)) out_slice (
        .clk     (clk),
        .rst     (rst),
        .s_data  (chk_data),
        .s_valid (chk_valid),
        .s_last  (chk_last),
        .s_ready (chk_ready),
        .m_data  (out_data),
        .m_valid (out_valid),
        .m_last  (out_last),
        .m_ready (out_ready)
    );

endmodule

// File: tests/stream_proc_tb.sv
`timescale 1ns/1ns

module stream_proc_tb;

    localparam int NUM_PKTS = 15;

    logic       clk;
    logic       rst;
    logic [7:0] in_data;
    logic       in_valid;
    logic       in_ready;
    logic       in_last;
    logic [7:0] out_data;
    logic       out_valid;
    logic       out_ready;
    logic       out_last;

    // packet table with one array per column for test number, header, length and first byte
    int         pkt_test  [NUM_PKTS] = '{1, 2, 2, 3, 3, 3, 4, 4, 4, 5, 5, 5, 5, 5, 5};
    logic [7:0] pkt_hdr   [NUM_PKTS] = '{8'h00, 8'h6A, 8'hBF, 8'hC5, 8'hC0, 8'h00, 8'h41,
                                         8'h80, 8'h00, 8'h00, 8'h55, 8'hC3, 8'h9C, 8'h40,
                                         8'h7F};
    int         pkt_len   [NUM_PKTS] = '{4, 5, 6, 3, 0, 2, 0, 0, 0, 6, 3, 2, 6, 0, 1};
    logic [7:0] pkt_start [NUM_PKTS] = '{8'h10, 8'h30, 8'hF8, 8'h50, 8'h00, 8'h60, 8'h00,
                                         8'h00, 8'h00, 8'hA0, 8'h01, 8'h11, 8'hFC, 8'h00,
                                         8'hFF};
    string      test_name [5] = '{"pass packet", "xor and add packets", "drop then pass",
                                  "header only packets", "random stalls and gaps"};

    logic [7:0] exp_data_q [$];
    logic       exp_last_q [$];
    logic [7:0] exp_d;
    logic       exp_l;
    int         errors;
    int         tests_passed;
    int         tests_failed;
    int         cycles;
    int         cycle_limit;
    int         err_before;
    logic       stall_en;
    logic       gaps_on;

    stream_proc_top UUT (
        .clk       (clk),
        .rst       (rst),
        .in_data   (in_data),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_last   (in_last),
        .out_data  (out_data),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_last  (out_last)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // expected beats for one packet from the opcode rules
    task automatic model_packet(input logic [7:0] hdr, input int len, input logic [7:0] start);
        logic [1:0] op;
        logic [7:0] key;
        logic [7:0] raw;
        logic [7:0] res;
        logic [7:0] sum;
        op  = hdr[7:6];
        key = {2'b00, hdr[5:0]};
        sum = 8'h00;
        if (op != 2'd3) begin
            for (int i = 0; i < len; i++) begin
                raw = start + 8'(i);
                case (op)
                    2'd1: res = raw ^ key;
                    2'd2: res = raw + key;
                    default: res = raw;
                endcase
                sum = sum + res;
                exp_data_q.push_back(res);
                exp_last_q.push_back(1'b0);
            end
            exp_data_q.push_back(sum);
            exp_last_q.push_back(1'b1);
        end
    endtask

    // entered 1 ns after a rising edge and left 1 ns after the transfer edge
    task automatic send_beat(input logic [7:0] d, input logic l);
        int gap;
        gap = gaps_on ? int'($urandom % 4) : 0;
        if (gap > 0) begin
            in_valid = 1'b0;
            repeat (gap) begin
                @(posedge clk);
                #1;
            end
        end
        in_data  = d;
        in_last  = l;
        in_valid = 1'b1;
        @(negedge clk);
        while (!in_ready) @(negedge clk);
        @(posedge clk);
        #1;
    endtask

    task automatic drive_packet(input logic [7:0] hdr, input int len, input logic [7:0] start);
        send_beat(hdr, len == 0);
        for (int i = 0; i < len; i++) begin
            send_beat(start + 8'(i), i == len - 1);
        end
    endtask

    // random back-pressure only while stalls are enabled
    always @(posedge clk) begin
        #1;
        out_ready = stall_en ? (($urandom % 4) != 0) : 1'b1;
    end

    // output transfers are sampled mid-cycle where everything is settled
    always @(negedge clk) begin
        if (!rst && out_valid && out_ready) begin
            if (exp_data_q.size() == 0) begin
                $display("unexpected extra output beat with data %h", out_data);
                errors++;
            end else begin
                exp_d = exp_data_q.pop_front();
                exp_l = exp_last_q.pop_front();
                if (out_data !== exp_d) begin
                    $display("error: out_data = %h, expected %h", out_data, exp_d);
                    errors++;
                end
                if (out_last !== exp_l) begin
                    $display("error: out_last = %h, expected %h", out_last, exp_l);
                    errors++;
                end
            end
        end
    end

    always @(posedge clk) begin
        cycles = cycles + 1;
        if (cycle_limit > 0 && cycles >= cycle_limit) begin
            $display("timeout after %0d cycles, %0d expected output beats never arrived",
                     cycles, exp_data_q.size());
            $display("Simulation failed");
            $finish;
        end
    end

    initial begin
        void'($urandom(37));
        rst          = 1'b1;
        in_data      = 8'h00;
        in_valid     = 1'b0;
        in_last      = 1'b0;
        out_ready    = 1'b0;
        stall_en     = 1'b0;
        gaps_on      = 1'b0;
        errors       = 0;
        tests_passed = 0;
        tests_failed = 0;
        cycles       = 0;
        cycle_limit  = 200;
        for (int p = 0; p < NUM_PKTS; p++) begin
            cycle_limit += 20 * (1 + pkt_len[p]);
        end

        err_before = errors;
        // input slice holds ready low while reset is applied
        @(posedge clk);
        repeat (7) begin
            @(negedge clk);
            if (in_ready !== 1'b0) begin
                $display("error: in_ready = %h, expected 0", in_ready);
                errors++;
            end
            @(posedge clk);
        end
        #1;
        rst = 1'b0;

        // nothing may come out before the first input beat
        repeat (20) begin
            @(negedge clk);
            if (out_valid !== 1'b0) begin
                $display("error: out_valid = %h, expected 0", out_valid);
                errors++;
            end
        end
        $display("test 6 reset and idle: %s", (errors == err_before) ? "ok" : "FAILED");
        if (errors == err_before) tests_passed++;
        else tests_failed++;
        @(posedge clk);
        #1;

        for (int t = 1; t <= 5; t++) begin
            err_before = errors;
            stall_en   = (t == 5);
            gaps_on    = (t == 3) || (t == 5);
            for (int p = 0; p < NUM_PKTS; p++) begin
                if (pkt_test[p] == t) begin
                    model_packet(pkt_hdr[p], pkt_len[p], pkt_start[p]);
                    drive_packet(pkt_hdr[p], pkt_len[p], pkt_start[p]);
                end
            end
            in_valid = 1'b0;
            in_last  = 1'b0;
            while (exp_data_q.size() != 0) @(posedge clk);
            // a few more cycles to catch extra beats
            repeat (10) @(posedge clk);
            #1;
            stall_en = 1'b0;
            $display("test %0d %s: %s", t, test_name[t - 1],
                     (errors == err_before) ? "ok" : "FAILED");
            if (errors == err_before) tests_passed++;
            else tests_failed++;
        end

        $display("tests passed %0d, tests failed %0d, errors %0d",
                 tests_passed, tests_failed, errors);
        if (errors == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// File: filelist.f
src/stream_pkg.sv
src/byte_stream_if.sv
src/axis_register.sv
src/packet_decode.sv
src/payload_execute.sv
src/checksum_append.sv
src/stream_proc_top.sv
tests/stream_proc_tb.sv

// File: run_sim.sh
#!/bin/sh
# build with Verilator, run, and look for the pass message
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module stream_proc_tb -f filelist.f \
    -o stream_proc_sim || exit 1
output=$(./obj_dir/stream_proc_sim)
echo "$output"
echo "$output" | grep -q "^Simulation passed$" && exit 0 || exit 1
